/* src/cpu_cfg_pkg.sv */
package cpu_cfg_pkg;

    // Load/store queue sizing
    localparam int LSQ_DEPTH = 8;
    localparam int LSQ_IDX   = $clog2(LSQ_DEPTH);

    // Reorder buffer tag width
    localparam int ROB_IDX   = 5;

    // Register file indices
    localparam int PHY_IDX   = 6;
    localparam int ARCH_IDX  = 5;

    // Data path width
    localparam int XLEN      = 32;

endpackage

/* src/lsu_pkg.sv */
package lsu_pkg;

    // Bit 3 marks a store, bit 2 a zero-extended load, bits 1:0 the size
    typedef enum logic [3:0] {
        MEM_LB  = 4'b0000,
        MEM_LH  = 4'b0001,
        MEM_LW  = 4'b0010,
        MEM_LBU = 4'b0100,
        MEM_LHU = 4'b0101,
        MEM_SB  = 4'b1000,
        MEM_SH  = 4'b1001,
        MEM_SW  = 4'b1010
    } mem_op_e;

    localparam logic [1:0] SIZE_BYTE = 2'd0;
    localparam logic [1:0] SIZE_HALF = 2'd1;
    localparam logic [1:0] SIZE_WORD = 2'd2;

    typedef struct packed {
        logic       is_store;
        logic       is_unsigned;
        logic [1:0] size;
    } mem_op_f_t;

    // Same opcode word, seen as a whole or by field
    typedef union packed {
        mem_op_e   op;
        mem_op_f_t f;
    } mem_op_u;

    typedef struct packed {
        logic                             occupied;
        logic                             ready;
        logic [cpu_cfg_pkg::ROB_IDX-1:0]  rob_id;
        logic [cpu_cfg_pkg::PHY_IDX-1:0]  rd_phy;
        logic [cpu_cfg_pkg::ARCH_IDX-1:0] rd_arch;
        mem_op_u                          op;
        logic [cpu_cfg_pkg::XLEN-1:0]     addr;
        logic [3:0]                       mask;
        logic [cpu_cfg_pkg::XLEN-1:0]     wdata;
    } lsq_slot_t;

endpackage

/* src/lsu_itf.sv */
`timescale 1ns/1ps

// AGU result broadcast, one-cycle strobe
interface agu_lsq_itf;

    logic                            valid;
    logic [cpu_cfg_pkg::ROB_IDX-1:0] rob_id;
    logic [cpu_cfg_pkg::XLEN-1:0]    addr;
    logic [3:0]                      mask;
    logic [cpu_cfg_pkg::XLEN-1:0]    wdata;

    modport agu (
        output valid, rob_id, addr, mask, wdata
    );

    modport slot (
        input valid, rob_id, addr, mask, wdata
    );

endinterface

// One queue slot: control strobes in, record out
interface lsq_slot_itf;

    logic                  do_alloc;
    logic                  do_release;
    lsu_pkg::lsq_slot_t    rec;

    modport alloc (
        output do_alloc, do_release,
        input  rec
    );

    modport slot (
        input  do_alloc, do_release,
        output rec
    );

    modport issue (
        input rec
    );

endinterface

/* src/lsu_agu.sv */
`timescale 1ns/1ps

module lsu_agu (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            agu_valid,
    input  logic [cpu_cfg_pkg::ROB_IDX-1:0] agu_rob_id,
    input  lsu_pkg::mem_op_u                agu_op,
    input  logic [cpu_cfg_pkg::XLEN-1:0]    agu_base,
    input  logic [cpu_cfg_pkg::XLEN-1:0]    agu_imm,
    input  logic [cpu_cfg_pkg::XLEN-1:0]    agu_store_data,
    agu_lsq_itf.agu                         result
);

    logic [cpu_cfg_pkg::XLEN-1:0] eff_addr;
    logic [1:0]                   off;
    logic [3:0]                   mask;
    logic [cpu_cfg_pkg::XLEN-1:0] lane_data;

    assign eff_addr = agu_base + agu_imm;
    assign off      = eff_addr[1:0];

    // Byte lane placement
    always_comb begin
        unique case (agu_op.f.size)
            lsu_pkg::SIZE_BYTE: begin
                mask      = 4'b0001 << off;
                lane_data = agu_store_data << {off, 3'b000};
            end
            lsu_pkg::SIZE_HALF: begin
                mask      = 4'b0011 << {off[1], 1'b0};
                lane_data = agu_store_data << {off[1], 4'b0000};
            end
            default: begin
                mask      = 4'b1111;
                lane_data = agu_store_data;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            result.valid <= 1'b0;
        end else begin
            result.valid <= agu_valid;
        end
    end

    always_ff @(posedge clk) begin
        result.rob_id <= agu_rob_id;
        result.addr   <= eff_addr;
        result.mask   <= mask;
        result.wdata  <= lane_data;
    end

    size_legal: assert property (@(posedge clk) disable iff (rst)
        agu_valid |-> agu_op.f.size != 2'd3);

endmodule

/* src/lsq_alloc.sv */
`timescale 1ns/1ps

module lsq_alloc (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            dispatch_valid,
    output logic                            dispatch_ready,
    output logic [cpu_cfg_pkg::LSQ_IDX-1:0] head_idx,
    lsq_slot_itf.alloc                      slots [cpu_cfg_pkg::LSQ_DEPTH],
    input  logic                            dequeue
);

    logic [cpu_cfg_pkg::LSQ_IDX:0]   head_ptr;
    logic [cpu_cfg_pkg::LSQ_IDX:0]   tail_ptr;
    logic [cpu_cfg_pkg::LSQ_IDX-1:0] tail_idx;
    logic                            full;
    logic                            empty;
    logic                            enqueue;
    logic [cpu_cfg_pkg::LSQ_DEPTH-1:0] occ;

    assign head_idx = head_ptr[cpu_cfg_pkg::LSQ_IDX-1:0];
    assign tail_idx = tail_ptr[cpu_cfg_pkg::LSQ_IDX-1:0];

    // Same index, opposite wrap flag
    assign full  = (head_idx == tail_idx) &&
                   (head_ptr[cpu_cfg_pkg::LSQ_IDX] != tail_ptr[cpu_cfg_pkg::LSQ_IDX]);
    assign empty = (head_ptr == tail_ptr);

    assign dispatch_ready = ~full;
    assign enqueue        = dispatch_valid && dispatch_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            head_ptr <= '0;
            tail_ptr <= '0;
        end else begin
            if (enqueue) begin
                tail_ptr <= tail_ptr + 1'b1;
            end
            if (dequeue && !empty) begin
                head_ptr <= head_ptr + 1'b1;
            end
        end
    end

    for (genvar i = 0; i < cpu_cfg_pkg::LSQ_DEPTH; i++) begin : g_strobe
        assign slots[i].do_alloc   = enqueue && (tail_idx == (cpu_cfg_pkg::LSQ_IDX)'(i));
        assign slots[i].do_release = dequeue && !empty &&
                                     (head_idx == (cpu_cfg_pkg::LSQ_IDX)'(i));
        assign occ[i]              = slots[i].rec.occupied;
    end

    head_occupied: assert property (@(posedge clk) disable iff (rst)
        dequeue |-> occ[head_idx]);

endmodule

/* src/lsq_slot.sv */
`timescale 1ns/1ps

module lsq_slot (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [cpu_cfg_pkg::ROB_IDX-1:0]  dispatch_rob_id,
    input  lsu_pkg::mem_op_u                 dispatch_op,
    input  logic [cpu_cfg_pkg::PHY_IDX-1:0]  dispatch_rd_phy,
    input  logic [cpu_cfg_pkg::ARCH_IDX-1:0] dispatch_rd_arch,
    agu_lsq_itf.slot                         agu,
    lsq_slot_itf.slot                        slot
);

    lsu_pkg::lsq_slot_t r;
    logic               match;

    // Address broadcast for this entry
    assign match = r.occupied && agu.valid && (agu.rob_id == r.rob_id);

    always_ff @(posedge clk) begin
        if (rst) begin
            r.occupied <= 1'b0;
            r.ready    <= 1'b0;
        end else if (slot.do_alloc) begin
            r.occupied <= 1'b1;
            r.ready    <= 1'b0;
        end else if (slot.do_release) begin
            r.occupied <= 1'b0;
            r.ready    <= 1'b0;
        end else if (match) begin
            r.ready    <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (slot.do_alloc) begin
            r.rob_id  <= dispatch_rob_id;
            r.op      <= dispatch_op;
            r.rd_phy  <= dispatch_rd_phy;
            r.rd_arch <= dispatch_rd_arch;
        end
        if (match) begin
            r.addr  <= agu.addr;
            r.mask  <= agu.mask;
            r.wdata <= agu.wdata;
        end
    end

    assign slot.rec = r;

    single_wakeup: assert property (@(posedge clk) disable iff (rst)
        match |-> !r.ready);

endmodule

/* src/lsq_issue.sv */
`timescale 1ns/1ps

module lsq_issue (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [cpu_cfg_pkg::LSQ_IDX-1:0]  head_idx,
    lsq_slot_itf.issue                       slots [cpu_cfg_pkg::LSQ_DEPTH],
    input  logic [cpu_cfg_pkg::ROB_IDX-1:0]  rob_head,
    output logic [cpu_cfg_pkg::XLEN-1:0]     dmem_addr,
    output logic [3:0]                       dmem_rmask,
    output logic [3:0]                       dmem_wmask,
    output logic [cpu_cfg_pkg::XLEN-1:0]     dmem_wdata,
    input  logic [cpu_cfg_pkg::XLEN-1:0]     dmem_rdata,
    input  logic                             dmem_resp,
    output logic                             dequeue,
    output logic                             cdb_valid,
    output logic [cpu_cfg_pkg::ROB_IDX-1:0]  cdb_rob_id,
    output logic [cpu_cfg_pkg::PHY_IDX-1:0]  cdb_rd_phy,
    output logic [cpu_cfg_pkg::ARCH_IDX-1:0] cdb_rd_arch,
    output logic [cpu_cfg_pkg::XLEN-1:0]     cdb_value
);

    lsu_pkg::lsq_slot_t recs [cpu_cfg_pkg::LSQ_DEPTH];
    lsu_pkg::lsq_slot_t head;
    logic               go;
    logic               is_store;
    logic [1:0]         off;
    logic [7:0]         byte_sel;
    logic [15:0]        half_sel;

    for (genvar i = 0; i < cpu_cfg_pkg::LSQ_DEPTH; i++) begin : g_rec
        assign recs[i] = slots[i].rec;
    end

    assign head     = recs[head_idx];
    assign is_store = head.op.f.is_store;

    //////////////////////////////////////////////////
    // Issue gate and memory request
    //////////////////////////////////////////////////

    // Stores wait for the ROB head
    assign go = head.ready && (!is_store || head.rob_id == rob_head);

    assign dmem_addr  = {head.addr[31:2], 2'b00};
    assign dmem_rmask = (go && !is_store) ? head.mask : 4'b0000;
    assign dmem_wmask = (go && is_store) ? head.mask : 4'b0000;
    assign dmem_wdata = head.wdata;
    assign dequeue    = go && dmem_resp;

    //////////////////////////////////////////////////
    // Load extraction
    //////////////////////////////////////////////////

    assign off      = head.addr[1:0];
    assign byte_sel = dmem_rdata[{off, 3'b000} +: 8];
    assign half_sel = dmem_rdata[{off[1], 4'b0000} +: 16];

    always_comb begin
        unique case (head.op.op)
            lsu_pkg::MEM_LB:  cdb_value = {{24{byte_sel[7]}}, byte_sel};
            lsu_pkg::MEM_LBU: cdb_value = {24'd0, byte_sel};
            lsu_pkg::MEM_LH:  cdb_value = {{16{half_sel[15]}}, half_sel};
            lsu_pkg::MEM_LHU: cdb_value = {16'd0, half_sel};
            lsu_pkg::MEM_LW:  cdb_value = dmem_rdata;
            // Stores complete with zero
            default:          cdb_value = '0;
        endcase
    end

    assign cdb_valid   = dequeue;
    assign cdb_rob_id  = head.rob_id;
    assign cdb_rd_phy  = head.rd_phy;
    assign cdb_rd_arch = head.rd_arch;

    // Request held until the memory answers
    req_stable: assert property (@(posedge clk) disable iff (rst)
        (go && !dmem_resp) |=> go && $stable(dmem_addr) && $stable(dmem_wdata));

endmodule

/* src/lsu_top.sv */
`timescale 1ns/1ps

module lsu_top (
    input  logic                             clk,
    input  logic                             rst,

    input  logic                             dispatch_valid,
    output logic                             dispatch_ready,
    input  logic [cpu_cfg_pkg::ROB_IDX-1:0]  dispatch_rob_id,
    input  lsu_pkg::mem_op_u                 dispatch_op,
    input  logic [cpu_cfg_pkg::PHY_IDX-1:0]  dispatch_rd_phy,
    input  logic [cpu_cfg_pkg::ARCH_IDX-1:0] dispatch_rd_arch,

    input  logic                             agu_valid,
    input  logic [cpu_cfg_pkg::ROB_IDX-1:0]  agu_rob_id,
    input  lsu_pkg::mem_op_u                 agu_op,
    input  logic [cpu_cfg_pkg::XLEN-1:0]     agu_base,
    input  logic [cpu_cfg_pkg::XLEN-1:0]     agu_imm,
    input  logic [cpu_cfg_pkg::XLEN-1:0]     agu_store_data,

    input  logic [cpu_cfg_pkg::ROB_IDX-1:0]  rob_head,

    output logic [cpu_cfg_pkg::XLEN-1:0]     dmem_addr,
    output logic [3:0]                       dmem_rmask,
    output logic [3:0]                       dmem_wmask,
    output logic [cpu_cfg_pkg::XLEN-1:0]     dmem_wdata,
    input  logic [cpu_cfg_pkg::XLEN-1:0]     dmem_rdata,
    input  logic                             dmem_resp,

    output logic                             cdb_valid,
    output logic [cpu_cfg_pkg::ROB_IDX-1:0]  cdb_rob_id,
    output logic [cpu_cfg_pkg::PHY_IDX-1:0]  cdb_rd_phy,
    output logic [cpu_cfg_pkg::ARCH_IDX-1:0] cdb_rd_arch,
    output logic [cpu_cfg_pkg::XLEN-1:0]     cdb_value
);

    logic [cpu_cfg_pkg::LSQ_IDX-1:0] head_idx;
    logic                            dequeue;

    agu_lsq_itf  agu_if ();
    lsq_slot_itf slot_if [cpu_cfg_pkg::LSQ_DEPTH] ();

    lsu_agu u_agu (
        .clk            (clk),
        .rst            (rst),
        .agu_valid      (agu_valid),
        .agu_rob_id     (agu_rob_id),
        .agu_op         (agu_op),
        .agu_base       (agu_base),
        .agu_imm        (agu_imm),
        .agu_store_data (agu_store_data),
        .result         (agu_if)
    );

    lsq_alloc u_alloc (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .dispatch_ready (dispatch_ready),
        .head_idx       (head_idx),
        .slots          (slot_if),
        .dequeue        (dequeue)
    );

    for (genvar i = 0; i < cpu_cfg_pkg::LSQ_DEPTH; i++) begin : g_slot
        lsq_slot u_slot (
            .clk              (clk),
            .rst              (rst),
            .dispatch_rob_id  (dispatch_rob_id),
            .dispatch_op      (dispatch_op),
            .dispatch_rd_phy  (dispatch_rd_phy),
            .dispatch_rd_arch (dispatch_rd_arch),
            .agu              (agu_if),
            .slot             (slot_if[i])
        );
    end

    lsq_issue u_issue (
        .clk         (clk),
        .rst         (rst),
        .head_idx    (head_idx),
        .slots       (slot_if),
        .rob_head    (rob_head),
        .dmem_addr   (dmem_addr),
        .dmem_rmask  (dmem_rmask),
        .dmem_wmask  (dmem_wmask),
        .dmem_wdata  (dmem_wdata),
        .dmem_rdata  (dmem_rdata),
        .dmem_resp   (dmem_resp),
        .dequeue     (dequeue),
        .cdb_valid   (cdb_valid),
        .cdb_rob_id  (cdb_rob_id),
        .cdb_rd_phy  (cdb_rd_phy),
        .cdb_rd_arch (cdb_rd_arch),
        .cdb_value   (cdb_value)
    );

endmodule

/* sim/dmem_model.sv */
`timescale 1ns/1ps

module dmem_model (
    input  logic        clk,
    input  logic        rst,
    input  logic [1:0]  delay,
    input  logic [31:0] addr,
    input  logic [3:0]  rmask,
    input  logic [3:0]  wmask,
    input  logic [31:0] wdata,
    output logic [31:0] rdata,
    output logic        resp
);

    logic [31:0] mem [256];
    logic        req;
    logic        busy;
    logic [1:0]  cnt;

    task automatic load_word(input int idx, input logic [31:0] val);
        mem[idx] = val;
    endtask

    assign req   = (|rmask) || (|wmask);
    assign rdata = mem[addr[9:2]];

    // Latency taken from delay when the access starts
    always_comb begin
        resp = req && (busy ? (cnt == 2'd0) : (delay == 2'd0));
    end

    always @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            cnt  <= 2'd0;
        end else if (resp) begin
            busy <= 1'b0;
        end else if (req && !busy) begin
            busy <= 1'b1;
            cnt  <= delay - 2'd1;
        end else if (busy) begin
            cnt <= cnt - 2'd1;
        end
    end

    always @(posedge clk) begin
        if (!rst && resp) begin
            for (int b = 0; b < 4; b++) begin
                if (wmask[b]) begin
                    mem[addr[9:2]][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

/* sim/lsu_tb.sv */
`timescale 1ns/1ps

module lsu_tb;

    localparam int NUM_OPS = 300;
    localparam int DEPTH   = cpu_cfg_pkg::LSQ_DEPTH;

    logic        clk;
    logic        rst;
    logic        dispatch_valid;
    logic        dispatch_ready;
    logic [4:0]  dispatch_rob_id;
    logic [3:0]  dispatch_op;
    logic [5:0]  dispatch_rd_phy;
    logic [4:0]  dispatch_rd_arch;
    logic        agu_valid;
    logic [4:0]  agu_rob_id;
    logic [3:0]  agu_op;
    logic [31:0] agu_base;
    logic [31:0] agu_imm;
    logic [31:0] agu_store_data;
    logic [4:0]  rob_head;
    logic [31:0] dmem_addr;
    logic [3:0]  dmem_rmask;
    logic [3:0]  dmem_wmask;
    logic [31:0] dmem_wdata;
    logic [31:0] dmem_rdata;
    logic        dmem_resp;
    logic [1:0]  mem_delay;
    logic        cdb_valid;
    logic [4:0]  cdb_rob_id;
    logic [5:0]  cdb_rd_phy;
    logic [4:0]  cdb_rd_arch;
    logic [31:0] cdb_value;

    logic [31:0] lfsr;
    logic [31:0] model_mem [256];

    // Per ROB entry record of the op in flight
    logic [3:0]  op_code [32];
    logic [31:0] op_addr [32];
    logic [31:0] op_data [32];
    logic [5:0]  op_phy [32];
    logic [4:0]  op_arch [32];
    int          ready_cycle [32];

    int          order [$];
    int          pending [$];
    logic [4:0]  next_rob;
    int          issued;
    int          done_cnt;
    int          cycle;
    logic        agu_hold;

    // One non-memory op in the ROB, and how many queued ops are older
    logic        alu_busy;
    logic [4:0]  alu_rob;
    int          alu_behind;

    lsu_top UUT (.*);

    dmem_model u_mem (
        .clk   (clk),
        .rst   (rst),
        .delay (mem_delay),
        .addr  (dmem_addr),
        .rmask (dmem_rmask),
        .wmask (dmem_wmask),
        .wdata (dmem_wdata),
        .rdata (dmem_rdata),
        .resp  (dmem_resp)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        #((16 + NUM_OPS * 20) * 100);
        report_failure("Timeout: not all memory ops completed in time");
    end

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped");
    endtask

    function automatic logic [3:0] lane_mask(input logic [3:0] code, input logic [1:0] off);
        case (code[1:0])
            2'd0:    return 4'b0001 << off;
            2'd1:    return 4'b0011 << (off & 2'b10);
            default: return 4'b1111;
        endcase
    endfunction

    function automatic logic [31:0] lane_data(input logic [3:0] code, input logic [1:0] off,
                                              input logic [31:0] d);
        case (code[1:0])
            2'd0:    return d << (8 * off);
            2'd1:    return d << (16 * off[1]);
            default: return d;
        endcase
    endfunction

    function automatic logic [31:0] load_value(input logic [3:0] code, input logic [31:0] a);
        logic [31:0] w;
        logic [7:0]  b;
        logic [15:0] h;
        w = model_mem[a[9:2]];
        b = w[8*a[1:0] +: 8];
        h = w[16*a[1] +: 16];
        case (code)
            4'b0000: return {{24{b[7]}}, b};
            4'b0100: return {24'd0, b};
            4'b0001: return {{16{h[15]}}, h};
            4'b0101: return {16'd0, h};
            4'b0010: return w;
            default: return 32'd0;
        endcase
    endfunction

    task automatic drive_inputs();
        logic [31:0] a;
        logic [31:0] imm;
        logic        imm_sign;
        int          idx;
        int          r;
        logic [3:0]  codes [8];
        codes = '{4'b0000, 4'b0001, 4'b0010, 4'b0100, 4'b0101, 4'b1000, 4'b1001, 4'b1010};
        mem_delay      = rand_bits(2);
        if (alu_busy && rand_bits(2) == 2'd0) begin
            alu_busy = 1'b0;
        end
        rob_head       = (alu_busy && alu_behind == 0) ? alu_rob :
                         (order.size() > 0) ? order[0][4:0] : next_rob;
        dispatch_valid = 1'b0;
        agu_valid      = 1'b0;
        if (issued < NUM_OPS && dispatch_ready && rand_bits(1)) begin
            // Sometimes a non-memory op takes the ROB entry ahead
            if (!alu_busy && rand_bits(2) == 2'd0) begin
                alu_busy   = 1'b1;
                alu_rob    = next_rob;
                alu_behind = order.size();
                next_rob   = next_rob + 5'd1;
            end
            op_code[next_rob] = codes[rand_bits(3)];
            a = {22'd0, 10'(rand_bits(10))};
            if (op_code[next_rob][1:0] == 2'd1) a[0] = 1'b0;
            if (op_code[next_rob][1:0] == 2'd2) a[1:0] = 2'b00;
            op_addr[next_rob]     = a;
            op_data[next_rob]     = rand_bits(32);
            op_phy[next_rob]      = rand_bits(6);
            op_arch[next_rob]     = rand_bits(5);
            ready_cycle[next_rob] = 32'h7fff_ffff;
            dispatch_valid   = 1'b1;
            dispatch_rob_id  = next_rob;
            dispatch_op      = op_code[next_rob];
            dispatch_rd_phy  = op_phy[next_rob];
            dispatch_rd_arch = op_arch[next_rob];
        end
        // AGU results in random order among enqueued ops
        if (!agu_hold && pending.size() > 0 && rand_bits(1)) begin
            idx = rand_bits(3) % pending.size();
            r   = pending[idx];
            pending.delete(idx);
            imm_sign       = rand_bits(1);
            imm            = {{27{imm_sign}}, 5'(rand_bits(5))};
            agu_valid      = 1'b1;
            agu_rob_id     = r[4:0];
            agu_op         = op_code[r];
            agu_imm        = imm;
            agu_base       = op_addr[r] - imm;
            agu_store_data = op_data[r];
            ready_cycle[r] = cycle + 2;
        end
    endtask

    task automatic check_outputs();
        int          f;
        logic        go;
        logic [1:0]  off;
        logic [3:0]  m;
        go = 1'b0;
        f  = 0;
        assert (dispatch_ready == (order.size() < DEPTH)) else
            report_failure($sformatf("Error at %0t: dispatch_ready %0b with %0d ops queued",
                                     $time, dispatch_ready, order.size()));
        if (order.size() > 0) begin
            f  = order[0];
            go = (cycle >= ready_cycle[f]) && (!op_code[f][3] || rob_head == f[4:0]);
        end
        off = op_addr[f][1:0];
        m   = lane_mask(op_code[f], off);
        assert (dmem_rmask == ((go && !op_code[f][3]) ? m : 4'b0000)) else
            report_failure($sformatf("Error at %0t: dmem_rmask %h", $time, dmem_rmask));
        assert (dmem_wmask == ((go && op_code[f][3]) ? m : 4'b0000)) else
            report_failure($sformatf("Error at %0t: dmem_wmask %h", $time, dmem_wmask));
        if (dmem_wmask != 4'b0000) begin
            assert (rob_head == f[4:0]) else
                report_failure($sformatf("Error at %0t: store issued with ROB head %0d",
                                         $time, rob_head));
        end
        if (go) begin
            assert (dmem_addr == {op_addr[f][31:2], 2'b00}) else
                report_failure($sformatf("Error at %0t: dmem_addr %h", $time, dmem_addr));
            if (op_code[f][3]) begin
                assert ((dmem_wdata & {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}}) ==
                        (lane_data(op_code[f], off, op_data[f]) &
                         {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}})) else
                    report_failure($sformatf("Error at %0t: dmem_wdata %h", $time, dmem_wdata));
            end
        end
        assert (cdb_valid == (go && dmem_resp)) else
            report_failure($sformatf("Error at %0t: cdb_valid %0b", $time, cdb_valid));
        if (cdb_valid) begin
            assert (cdb_rob_id == f[4:0] && cdb_rd_phy == op_phy[f] &&
                    cdb_rd_arch == op_arch[f]) else
                report_failure($sformatf("Error at %0t: bus tags rob %0d phy %0d arch %0d",
                                         $time, cdb_rob_id, cdb_rd_phy, cdb_rd_arch));
            assert (cdb_value == load_value(op_code[f], op_addr[f])) else
                report_failure($sformatf("Error at %0t: cdb_value %h, expected %h", $time,
                                         cdb_value, load_value(op_code[f], op_addr[f])));
            if (op_code[f][3]) begin
                for (int b = 0; b < 4; b++) begin
                    if (m[b]) begin
                        model_mem[op_addr[f][9:2]][8*b +: 8] =
                            lane_data(op_code[f], off, op_data[f])[8*b +: 8];
                    end
                end
            end
            void'(order.pop_front());
            if (alu_busy && alu_behind > 0) begin
                alu_behind--;
            end
            done_cnt++;
        end
        if (dispatch_valid) begin
            order.push_back(next_rob);
            pending.push_back(next_rob);
            next_rob = next_rob + 5'd1;
            issued++;
        end
        // Queue seen full with no addresses, now let the AGU run
        if (agu_hold && !dispatch_ready) begin
            agu_hold = 1'b0;
        end
    endtask

    initial begin
        lfsr             = 32'hc265_2303;
        rst              = 1'b1;
        dispatch_valid   = 1'b0;
        dispatch_rob_id  = '0;
        dispatch_op      = '0;
        dispatch_rd_phy  = '0;
        dispatch_rd_arch = '0;
        agu_valid        = 1'b0;
        agu_rob_id       = '0;
        agu_op           = '0;
        agu_base         = '0;
        agu_imm          = '0;
        agu_store_data   = '0;
        rob_head         = '0;
        mem_delay        = '0;
        next_rob         = '0;
        issued           = 0;
        done_cnt         = 0;
        cycle            = 0;
        agu_hold         = 1'b1;
        alu_busy         = 1'b0;
        alu_rob          = '0;
        alu_behind       = 0;
        for (int i = 0; i < 256; i++) begin
            model_mem[i] = rand_bits(32);
            u_mem.load_word(i, model_mem[i]);
        end
        repeat (16) @(negedge clk);
        rst = 1'b0;
        #40;
        assert (dispatch_ready && !cdb_valid && dmem_rmask == 0 && dmem_wmask == 0) else
            report_failure($sformatf("Error at %0t: outputs not idle after reset", $time));
        @(negedge clk);
        while (done_cnt < NUM_OPS) begin
            drive_inputs();
            #40;
            check_outputs();
            cycle++;
            @(negedge clk);
        end
        for (int i = 0; i < 256; i++) begin
            assert (u_mem.mem[i] == model_mem[i]) else
                report_failure($sformatf("Error at %0t: memory word %0d is %h, expected %h",
                                         $time, i, u_mem.mem[i], model_mem[i]));
        end
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* list.f */
src/cpu_cfg_pkg.sv
src/lsu_pkg.sv
src/lsu_itf.sv
src/lsu_agu.sv
src/lsq_alloc.sv
src/lsq_slot.sv
src/lsq_issue.sv
src/lsu_top.sv
sim/dmem_model.sv
sim/lsu_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the LSU testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f list.f --top-module lsu_tb -o lsu_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/lsu_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Simulation finished: FAIL" "$LOG"; then
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "Simulator exited with status $run_status"
    exit 1
fi
if ! grep -q "Simulation finished: PASS" "$LOG"; then
    echo "Simulation ended without a result"
    exit 1
fi
exit 0
